/* Bender.yml */
package:
  name: ooo_backend

sources:
  - files:
      - source/backend_pkg.sv
      - source/fu_pipe.sv
      - source/reorder_buffer.sv
      - source/issue_control.sv
      - source/alu_unit.sv
      - source/mul_unit.sv
      - source/arch_regfile.sv
      - source/ooo_backend.sv
  - target: test
    files:
      - test/rob_checker.sv
      - test/tb_ooo_backend.sv

/* compile.f */
source/backend_pkg.sv
source/fu_pipe.sv
source/reorder_buffer.sv
source/issue_control.sv
source/alu_unit.sv
source/mul_unit.sv
source/arch_regfile.sv
source/ooo_backend.sv
test/rob_checker.sv
test/tb_ooo_backend.sv

/* source/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   alu_issue,
    input  op_t                    issue_op,
    input  logic [rob_tag_len-1:0] issue_tag,
    input  logic [xlen-1:0]        issue_a,
    input  logic [xlen-1:0]        issue_b,
    output logic                   alu_done,
    output alu_result_t            alu_result
);

    alu_result_t result;

    always_comb begin
        result.tag        = issue_tag;
        result.data       = '0;
        result.mispredict = 1'b0;
        case (issue_op)
            op_add: result.data = issue_a + issue_b;
            op_sub: result.data = issue_a - issue_b;
            op_xor: result.data = issue_a ^ issue_b;
            op_beq: begin
                result.data       = issue_a - issue_b;
                result.mispredict = (issue_a == issue_b);  // Predicted not taken
            end
            default: result.data = '0;
        endcase
    end

    fu_pipe #(
        .depth     (1),
        .payload_t (alu_result_t)
    ) alu_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (alu_issue),
        .in_payload  (result),
        .out_valid   (alu_done),
        .out_payload (alu_result)
    );

endmodule

`default_nettype wire

/* source/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    retire_valid,
    input  logic [reg_addr_len-1:0] retire_reg,
    input  logic [xlen-1:0]         retire_data,
    input  logic [reg_addr_len-1:0] rd_addr,
    output logic [xlen-1:0]         rd_data
);

    logic [xlen-1:0] regs [2**reg_addr_len];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_len; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid && retire_reg != '0) begin  // r0 stays zero
            regs[retire_reg] <= retire_data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

/* source/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    localparam int xlen         = 16;
    localparam int reg_addr_len = 3;
    localparam int rob_size     = 8;
    localparam int rob_tag_len  = 3;
    localparam int mul_depth    = 3;

    // op_beq is predicted not taken
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_mul,
        op_beq
    } op_t;

    typedef struct packed {
        logic                    valid;
        logic                    ready;      // Result written back
        logic                    mispredict;
        logic [reg_addr_len-1:0] wb_reg;
        logic [xlen-1:0]         wb_data;
    } rob_entry_t;

    typedef struct packed {
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        data;
        logic                   mispredict;
    } alu_result_t;

    typedef struct packed {
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        data;       // Low half of the product
    } mul_result_t;

endpackage

`default_nettype wire

/* source/fu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_pipe #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    logic     valid_q   [depth];
    payload_t payload_q [depth];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < depth; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < depth; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload only matters where the valid bit is set
    always_ff @(posedge clk) begin
        payload_q[0] <= in_payload;
        for (int i = 1; i < depth; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign out_valid   = valid_q[depth-1];
    assign out_payload = payload_q[depth-1];

endmodule

`default_nettype wire

/* source/issue_control.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_control
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  op_t                     instr_op,
    input  logic [xlen-1:0]         instr_a,
    input  logic [xlen-1:0]         instr_b,
    input  logic [reg_addr_len-1:0] instr_dest,
    input  logic                    rob_full_next,
    input  logic                    flush,
    input  logic [rob_tag_len-1:0]  alloc_tag,
    output logic                    stall,
    output logic                    dispatch,
    output logic [reg_addr_len-1:0] dispatch_reg,
    output logic                    alu_issue,
    output logic                    mul_issue,
    output op_t                     issue_op,
    output logic [rob_tag_len-1:0]  issue_tag,
    output logic [xlen-1:0]         issue_a,
    output logic [xlen-1:0]         issue_b
);

    logic is_mul;
    logic is_branch;

    assign is_mul    = (instr_op == op_mul);
    assign is_branch = (instr_op == op_beq);

    // Instructions offered during a flush are dropped
    assign dispatch     = instr_valid && !stall && !flush;
    assign dispatch_reg = is_branch ? '0 : instr_dest;  // Branches write r0

    assign alu_issue = dispatch && !is_mul;
    assign mul_issue = dispatch && is_mul;

    assign issue_op  = instr_op;
    assign issue_tag = alloc_tag;
    assign issue_a   = instr_a;
    assign issue_b   = instr_b;

    // Registered full flag keeps the dispatch path free of loops
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stall <= 1'b0;
        end else begin
            stall <= rob_full_next;
        end
    end

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import backend_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   mul_issue,
    input  logic [rob_tag_len-1:0] issue_tag,
    input  logic [xlen-1:0]        issue_a,
    input  logic [xlen-1:0]        issue_b,
    output logic                   mul_done,
    output mul_result_t            mul_result
);

    logic [xlen-1:0] product;
    mul_result_t     result;

    assign product = issue_a * issue_b;  // Truncated to xlen

    always_comb begin
        result.tag  = issue_tag;
        result.data = product;
    end

    // First stage captures the product, the rest only delay it
    fu_pipe #(
        .depth     (mul_depth),
        .payload_t (mul_result_t)
    ) mul_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (mul_issue),
        .in_payload  (result),
        .out_valid   (mul_done),
        .out_payload (mul_result)
    );

endmodule

`default_nettype wire

/* source/ooo_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_backend
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  op_t                     instr_op,
    input  logic [reg_addr_len-1:0] instr_dest,
    input  logic [xlen-1:0]         instr_a,
    input  logic [xlen-1:0]         instr_b,
    input  logic [reg_addr_len-1:0] rd_addr,
    output logic                    stall,
    output logic                    retire_valid,
    output logic [reg_addr_len-1:0] retire_reg,
    output logic [xlen-1:0]         retire_data,
    output logic                    flush,
    output logic [xlen-1:0]         rd_data
);

    logic                    dispatch;
    logic [reg_addr_len-1:0] dispatch_reg;
    logic [rob_tag_len-1:0]  alloc_tag;
    logic                    rob_full_next;
    logic                    alu_issue;
    logic                    mul_issue;
    op_t                     issue_op;
    logic [rob_tag_len-1:0]  issue_tag;
    logic [xlen-1:0]         issue_a;
    logic [xlen-1:0]         issue_b;
    logic                    alu_done;
    alu_result_t             alu_result;
    logic                    mul_done;
    mul_result_t             mul_result;

    issue_control issue_control_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_a       (instr_a),
        .instr_b       (instr_b),
        .instr_dest    (instr_dest),
        .rob_full_next (rob_full_next),
        .flush         (flush),
        .alloc_tag     (alloc_tag),
        .stall         (stall),
        .dispatch      (dispatch),
        .dispatch_reg  (dispatch_reg),
        .alu_issue     (alu_issue),
        .mul_issue     (mul_issue),
        .issue_op      (issue_op),
        .issue_tag     (issue_tag),
        .issue_a       (issue_a),
        .issue_b       (issue_b)
    );

    reorder_buffer reorder_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch),
        .dispatch_reg  (dispatch_reg),
        .alu_done      (alu_done),
        .alu_result    (alu_result),
        .mul_done      (mul_done),
        .mul_result    (mul_result),
        .alloc_tag     (alloc_tag),
        .rob_full_next (rob_full_next),
        .retire_valid  (retire_valid),
        .retire_reg    (retire_reg),
        .retire_data   (retire_data),
        .flush         (flush)
    );

    alu_unit alu_unit_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .alu_issue  (alu_issue),
        .issue_op   (issue_op),
        .issue_tag  (issue_tag),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .alu_done   (alu_done),
        .alu_result (alu_result)
    );

    mul_unit mul_unit_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .mul_issue  (mul_issue),
        .issue_tag  (issue_tag),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

    arch_regfile arch_regfile_i (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dispatch,
    input  logic [reg_addr_len-1:0] dispatch_reg,
    input  logic                    alu_done,
    input  alu_result_t             alu_result,
    input  logic                    mul_done,
    input  mul_result_t             mul_result,
    output logic [rob_tag_len-1:0]  alloc_tag,
    output logic                    rob_full_next,
    output logic                    retire_valid,
    output logic [reg_addr_len-1:0] retire_reg,
    output logic [xlen-1:0]         retire_data,
    output logic                    flush
);

    rob_entry_t rob      [rob_size];
    rob_entry_t rob_next [rob_size];

    logic [rob_tag_len-1:0] head;
    logic [rob_tag_len-1:0] head_next;
    logic [rob_tag_len-1:0] tail;
    logic [rob_tag_len-1:0] tail_next;
    logic [rob_tag_len:0]   count;
    logic [rob_tag_len:0]   count_next;

    always_comb begin
        rob_next     = rob;
        head_next    = head;
        tail_next    = tail;
        retire_valid = 1'b0;
        retire_reg   = '0;
        retire_data  = '0;
        flush        = 1'b0;

        if (dispatch) begin
            rob_next[tail].valid      = 1'b1;
            rob_next[tail].ready      = 1'b0;
            rob_next[tail].mispredict = 1'b0;
            rob_next[tail].wb_reg     = dispatch_reg;
            rob_next[tail].wb_data    = '0;
            tail_next                 = tail + 1'b1;  // Wraps at rob_size
        end

        if (alu_done) begin
            rob_next[alu_result.tag].wb_data    = alu_result.data;
            rob_next[alu_result.tag].mispredict = alu_result.mispredict;
            rob_next[alu_result.tag].ready      = 1'b1;
        end

        if (mul_done) begin
            rob_next[mul_result.tag].wb_data    = mul_result.data;
            rob_next[mul_result.tag].mispredict = 1'b0;
            rob_next[mul_result.tag].ready      = 1'b1;
        end

        // Retire the oldest entry once its result is in
        if (rob[head].valid && rob[head].ready) begin
            retire_valid         = 1'b1;
            retire_reg           = rob[head].wb_reg;
            retire_data          = rob[head].wb_data;
            flush                = rob[head].mispredict;
            rob_next[head].valid = 1'b0;
            head_next            = head + 1'b1;
        end
    end

    always_comb begin
        count_next = count + {{rob_tag_len{1'b0}}, dispatch}
                           - {{rob_tag_len{1'b0}}, retire_valid};
    end

    assign alloc_tag     = tail;
    assign rob_full_next = !flush && (count_next == (rob_tag_len+1)'(rob_size));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                rob[i].valid <= 1'b0;
                rob[i].ready <= 1'b0;
            end
        end else begin
            rob   <= rob_next;
            head  <= head_next;
            tail  <= tail_next;
            count <= count_next;
        end
    end

    // Units only complete work that is still in flight
    alu_done_valid_entry: assert property (@(posedge clk) disable iff (rst)
        alu_done |-> rob[alu_result.tag].valid)
        else $error("ALU completion to invalid tag %0d", alu_result.tag);

    mul_done_valid_entry: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> rob[mul_result.tag].valid)
        else $error("MUL completion to invalid tag %0d", mul_result.tag);

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        dispatch |-> count != (rob_tag_len+1)'(rob_size))
        else $error("Dispatch into a full buffer");

endmodule

`default_nettype wire

/* test/backend_stimulus.txt */
# Columns: op dest a b result mispredict, with a, b and result in hex
# Keywords: random <count> draws instructions, drain waits until all have retired
# Arithmetic
add 1 0005 0003 0008 0
sub 2 0010 0003 000d 0
xor 3 00ff 0f0f 0ff0 0
mul 4 0012 0034 03a8 0
mul 5 1234 0100 3400 0
sub 6 0003 0005 fffe 0
drain
# Program order with a multiply ahead of ALU work
mul 1 0007 0009 003f 0
add 2 0001 0001 0002 0
xor 3 aaaa 5555 ffff 0
sub 4 0100 0001 00ff 0
drain
# Burst of multiplies
mul 1 0002 0003 0006 0
mul 2 0004 0005 0014 0
mul 3 0006 0007 002a 0
mul 4 0008 0009 0048 0
mul 5 000a 000b 006e 0
mul 6 000c 000d 009c 0
mul 7 000e 000f 00d2 0
mul 1 0010 0011 0110 0
mul 2 ffff ffff 0001 0
drain
# Branch not taken, then a mispredicted one
beq 0 0005 0003 0002 0
beq 0 0009 0009 0000 1
add 5 0001 0002 0003 0
mul 6 0003 0003 0009 0
add 7 0004 0004 0008 0
sub 3 0020 0001 001f 0
drain
# Random mix
random 40
drain

/* test/rob_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_checker
    import backend_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  op_t                     instr_op,
    input  logic [reg_addr_len-1:0] instr_dest,
    input  logic [xlen-1:0]         exp_data,
    input  logic                    exp_mispredict,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    retire_valid,
    input  logic [reg_addr_len-1:0] retire_reg,
    input  logic [xlen-1:0]         retire_data,
    input  logic                    reg_check,
    input  logic [reg_addr_len-1:0] rd_addr,
    input  logic [xlen-1:0]         rd_data,
    output int                      error_count,
    output int                      retire_count,
    output int                      drop_count,
    output int                      flush_count,
    output int                      stall_cycles,
    output int                      pending
);

    typedef struct packed {
        logic [reg_addr_len-1:0] wb_reg;
        logic [xlen-1:0]         data;
        logic                    mispredict;
    } expect_t;

    expect_t         expected_q [$];  // Accepted instructions in program order
    expect_t         oldest;
    expect_t         incoming;
    logic [xlen-1:0] model_regs [2**reg_addr_len];

    // Mid-cycle sampling, registered outputs have settled
    always @(negedge clk) begin
        if (rst) begin
            expected_q.delete();
            for (int i = 0; i < 2**reg_addr_len; i++) begin
                model_regs[i] = '0;
            end
            error_count  = 0;
            retire_count = 0;
            drop_count   = 0;
            flush_count  = 0;
            stall_cycles = 0;
            pending      = 0;
        end else begin
            // Stall follows a full buffer as of the last edge
            if (stall !== (expected_q.size() == rob_size)) begin
                $display("[ERROR] %0t: stall is %b with %0d instructions in flight",
                         $time, stall, expected_q.size());
                error_count++;
            end

            if (retire_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Retirement at %0t with no instruction outstanding", $time);
                    error_count++;
                end else begin
                    oldest = expected_q.pop_front();
                    retire_count++;
                    if (retire_reg !== oldest.wb_reg || retire_data !== oldest.data) begin
                        $display("[ERROR] %0t: retired r%0d = %h, expected r%0d = %h",
                                 $time, retire_reg, retire_data, oldest.wb_reg, oldest.data);
                        error_count++;
                    end
                    if (flush !== oldest.mispredict) begin
                        $display("[ERROR] %0t: flush is %b at retirement, expected %b",
                                 $time, flush, oldest.mispredict);
                        error_count++;
                    end
                    if (oldest.wb_reg != '0) begin
                        model_regs[oldest.wb_reg] = oldest.data;
                    end
                    if (oldest.mispredict) begin  // Younger work is squashed
                        drop_count += expected_q.size();
                        flush_count++;
                        expected_q.delete();
                    end
                end
            end else if (flush) begin
                $display("Flush at %0t without a retirement", $time);
                error_count++;
            end

            if (stall) begin
                stall_cycles++;
            end

            if (instr_valid && !stall && !flush) begin
                incoming.wb_reg     = (instr_op == op_beq) ? '0 : instr_dest;  // Branches write r0
                incoming.data       = exp_data;
                incoming.mispredict = exp_mispredict;
                expected_q.push_back(incoming);
            end

            if (reg_check && rd_data !== model_regs[rd_addr]) begin
                $display("[ERROR] %0t: r%0d reads %h, expected %h",
                         $time, rd_addr, rd_data, model_regs[rd_addr]);
                error_count++;
            end

            pending = expected_q.size();
        end
    end

endmodule

`default_nettype wire

/* test/tb_ooo_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_backend
    import backend_pkg::*;
();

    localparam int clk_period    = 100;
    localparam int drive_delay   = 1;
    localparam int stall_timeout = 50;
    localparam int drain_timeout = 100;

    logic                    clk;
    logic                    rst;
    logic                    instr_valid;
    op_t                     instr_op;
    logic [reg_addr_len-1:0] instr_dest;
    logic [xlen-1:0]         instr_a;
    logic [xlen-1:0]         instr_b;
    logic [reg_addr_len-1:0] rd_addr;
    logic                    stall;
    logic                    retire_valid;
    logic [reg_addr_len-1:0] retire_reg;
    logic [xlen-1:0]         retire_data;
    logic                    flush;
    logic [xlen-1:0]         rd_data;
    logic [xlen-1:0]         exp_data;
    logic                    exp_mispredict;
    logic                    reg_check;
    int                      error_count;
    int                      retire_count;
    int                      drop_count;
    int                      flush_count;
    int                      stall_cycles;
    int                      pending;
    bit                      run_failed;
    logic [31:0]             lcg_state;

    ooo_backend ooo_backend_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_op     (instr_op),
        .instr_dest   (instr_dest),
        .instr_a      (instr_a),
        .instr_b      (instr_b),
        .rd_addr      (rd_addr),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data),
        .flush        (flush),
        .rd_data      (rd_data)
    );

    rob_checker rob_checker_i (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr_op       (instr_op),
        .instr_dest     (instr_dest),
        .exp_data       (exp_data),
        .exp_mispredict (exp_mispredict),
        .stall          (stall),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire_reg     (retire_reg),
        .retire_data    (retire_data),
        .reg_check      (reg_check),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .error_count    (error_count),
        .retire_count   (retire_count),
        .drop_count     (drop_count),
        .flush_count    (flush_count),
        .stall_cycles   (stall_cycles),
        .pending        (pending)
    );

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [xlen-1:0] expected_data(input op_t op, input logic [xlen-1:0] a,
                                                      input logic [xlen-1:0] b);
        logic [2*xlen-1:0] product;
        product = a * b;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_mul:  return product[xlen-1:0];
            default: return a - b;  // Branch reports the operand difference
        endcase
    endfunction

    task automatic parse_op(input logic [63:0] word, output op_t op, output bit ok);
        ok = 1'b1;
        op = op_add;
        if (word == "add") op = op_add;
        else if (word == "sub") op = op_sub;
        else if (word == "xor") op = op_xor;
        else if (word == "mul") op = op_mul;
        else if (word == "beq") op = op_beq;
        else ok = 1'b0;
    endtask

    // Holds the instruction while stall is high, moves on once taken or flushed away
    task automatic issue_instr(input op_t op, input logic [reg_addr_len-1:0] dest,
                               input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                               input logic [xlen-1:0] res, input logic mis);
        int waited;
        waited         = 0;
        instr_valid    = 1'b1;
        instr_op       = op;
        instr_dest     = dest;
        instr_a        = a;
        instr_b        = b;
        exp_data       = res;
        exp_mispredict = mis;
        @(negedge clk);
        while (stall && waited < stall_timeout) begin
            waited++;
            @(negedge clk);
        end
        if (stall) begin
            $display("Timeout: stall stayed high for %0d cycles", stall_timeout);
            run_failed = 1'b1;
        end
        @(posedge clk);
        #drive_delay;
        instr_valid = 1'b0;
    endtask

    task automatic drain_backend();
        int waited;
        waited      = 0;
        instr_valid = 1'b0;
        while (pending != 0 && waited < drain_timeout) begin
            waited++;
            @(posedge clk);
            #drive_delay;
        end
        if (pending != 0) begin
            $display("Timeout: %0d instructions never retired", pending);
            run_failed = 1'b1;
        end
    endtask

    task automatic run_random(input int count);
        op_t                     op;
        logic [reg_addr_len-1:0] dest;
        logic [xlen-1:0]         a;
        logic [xlen-1:0]         b;
        for (int i = 0; i < count && !run_failed; i++) begin
            lcg_state = lcg_next(lcg_state);
            op        = op_t'(3'((lcg_state >> 16) % 5));
            dest      = lcg_state[26:24];
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state[31:16];
            if (op == op_beq && lcg_state[20]) b = a;  // Some branches mispredict
            issue_instr(op, dest, a, b, expected_data(op, a, b), op == op_beq && a == b);
        end
    endtask

    task automatic check_registers();
        for (int r = 0; r < 2**reg_addr_len; r++) begin
            rd_addr   = reg_addr_len'(r);
            reg_check = 1'b1;
            @(posedge clk);
            #drive_delay;
        end
        reg_check = 1'b0;
    endtask

    task automatic finish_run();
        $display("Summary: %0d errors, %0d retired, %0d dropped, %0d flushes, %0d stall cycles",
                 error_count, retire_count, drop_count, flush_count, stall_cycles);
        if (flush_count == 0) $display("No mispredicted branch flushed the buffer");
        if (run_failed || error_count != 0 || flush_count == 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    endtask

    initial begin
        int              fd;
        int              fields;
        int              dest;
        int              count;
        int              mis;
        logic [8*96-1:0] line;
        logic [63:0]     word;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        op_t             op;
        bit              op_ok;

        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr_op       = op_add;
        instr_dest     = '0;
        instr_a        = '0;
        instr_b        = '0;
        rd_addr        = '0;
        exp_data       = '0;
        exp_mispredict = 1'b0;
        reg_check      = 1'b0;
        run_failed     = 1'b0;
        lcg_state      = 32'd76620;
        repeat (8) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        fd = $fopen("test/backend_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/backend_stimulus.txt");
            run_failed = 1'b1;
        end
        while (fd != 0 && !run_failed && !$feof(fd)) begin
            line = '0;
            word = '0;
            if ($fgets(line, fd) == 0) continue;
            fields = $sscanf(line, "%s", word);
            if (fields < 1 || word == "#") continue;
            if (word == "drain") begin
                drain_backend();
            end else if (word == "random") begin
                fields = $sscanf(line, "%s %d", word, count);
                run_random(count);
            end else begin
                fields = $sscanf(line, "%s %d %h %h %h %d", word, dest, a, b, res, mis);
                parse_op(word, op, op_ok);
                if (fields != 6 || !op_ok) begin
                    $display("Malformed stimulus line: %0s", line);
                    run_failed = 1'b1;
                end else begin
                    issue_instr(op, dest[reg_addr_len-1:0], a, b, res, mis != 0);
                end
            end
        end
        if (fd != 0) $fclose(fd);

        if (!run_failed) drain_backend();
        if (!run_failed) check_registers();
        finish_run();
    end

endmodule

`default_nettype wire
